//--- tb.f
lut_pkg.sv
lut_unit.sv
lut_dp_ram.sv
lut_addr_gen.sv
lut_accum.sv
lut_bus_decode.sv
lut_top.sv
tb_lut_top.sv

//--- Bender.yml
package:
  name: lut_accel

sources:
  - lut_pkg.sv
  - lut_unit.sv
  - lut_dp_ram.sv
  - lut_addr_gen.sv
  - lut_accum.sv
  - lut_bus_decode.sv
  - lut_top.sv
  - target: test
    files:
      - tb_lut_top.sv

//--- tb_lut_top.sv
module tb_lut_top
   import lut_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TBL_WORDS = 1024;
   localparam int READ_TIMEOUT = 10;
   localparam int IDLE_TIMEOUT = 200;
   localparam logic [31:0] LFSR_SEED = 32'hda27;
   localparam logic [31:0] LFSR_TAPS = 32'ha300_0000;

   logic       clk;
   logic       rst;
   logic       valid;
   logic [3:0] wstrb;
   haddr_t     addr;
   word_t      wdata;
   logic       rvalid;
   word_t      rdata;

   word_t       shadow [TBL_WORDS];
   logic [31:0] lfsr_state;

   lut_top #(
      .DATA_W(DATA_W_DEF),
      .ADDR_W(ADDR_W_DEF)
   ) dut_i (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .wstrb (wstrb),
      .addr  (addr),
      .wdata (wdata),
      .rvalid(rvalid),
      .rdata (rdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return v;
   endfunction

   // Sum of both table words per step with indices wrapping at the table size
   function automatic word_t expected_sum(input word_t s0, input word_t s1,
                                          input word_t stride, input word_t count);
      word_t acc;
      word_t i0;
      word_t i1;
      acc = '0;
      for (int k = 0; k < int'(count); k++) begin
         i0 = (s0 + word_t'(k) * stride) % TBL_WORDS;
         i1 = (s1 + word_t'(k) * stride) % TBL_WORDS;
         acc = acc + shadow[i0] + shadow[i1];
      end
      return acc;
   endfunction

   function automatic haddr_t ctl_addr(input logic [2:0] offset);
      return {1'b1, 7'b0, offset, 2'b00};
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("Fail %s expected %08h actual %08h", name, expected, actual);
         abort_run("value mismatch");
      end
   endtask

   task automatic bus_write(input haddr_t a, input word_t d);
      @(posedge clk);
      #2;
      valid = 1'b1;
      wstrb = 4'hf;
      addr  = a;
      wdata = d;
      @(posedge clk);
      #2;
      valid = 1'b0;
      wstrb = 4'h0;
   endtask

   task automatic write_table(input int idx, input word_t d);
      bus_write({1'b0, idx[9:0], 2'b00}, d);
      shadow[idx] = d;
   endtask

   task automatic write_ctl(input logic [2:0] offset, input word_t d);
      bus_write(ctl_addr(offset), d);
   endtask

   task automatic read_ctl(input logic [2:0] offset, output word_t d);
      int   cycles;
      logic got;
      @(posedge clk);
      #2;
      valid = 1'b1;
      wstrb = 4'h0;
      addr  = ctl_addr(offset);
      @(posedge clk);
      #2;
      valid  = 1'b0;
      got    = 1'b0;
      cycles = 0;
      d      = '0;
      while (!got && cycles < READ_TIMEOUT) begin
         @(negedge clk);
         if (rvalid) begin
            d   = rdata;
            got = 1'b1;
         end
         cycles++;
      end
      if (!got) begin
         abort_run("control register read got no response");
      end
   endtask

   task automatic wait_idle();
      word_t status;
      int    polls;
      polls  = 0;
      status = 32'h1;
      while (status[0] && polls < IDLE_TIMEOUT) begin
         read_ctl(REG_STATUS, status);
         polls++;
      end
      if (status[0]) begin
         abort_run("busy never cleared after GO");
      end
   endtask

   task automatic configure(input word_t s0, input word_t s1, input word_t stride,
                            input word_t count);
      write_ctl(REG_START0, s0);
      write_ctl(REG_START1, s1);
      write_ctl(REG_STRIDE, stride);
      write_ctl(REG_COUNT, count);
   endtask

   task automatic go_and_check(input string name, input word_t s0, input word_t s1,
                               input word_t stride, input word_t count);
      word_t res;
      write_ctl(REG_GO, 32'h1);
      wait_idle();
      read_ctl(REG_RESULT, res);
      check(name, expected_sum(s0, s1, stride, count), res);
   endtask

   initial begin
      word_t v;
      word_t s0;
      word_t s1;
      word_t stride;
      word_t count;
      word_t first;
      word_t regs [4];

      rst   = 1'b1;
      valid = 1'b0;
      wstrb = 4'h0;
      addr  = '0;
      wdata = '0;
      lfsr_state = LFSR_SEED;
      for (int i = 0; i < TBL_WORDS; i++) begin
         shadow[i] = '0;
      end
      repeat (5) @(posedge clk);
      #2;
      rst = 1'b0;

      read_ctl(REG_STATUS, v);
      check("reset_status", 32'h0, v);
      read_ctl(REG_RESULT, v);
      check("reset_result", 32'h0, v);
      for (int i = 0; i < 4; i++) begin
         regs[i] = rand_bits(32);
         write_ctl(3'(i), regs[i]);
      end
      for (int i = 0; i < 4; i++) begin
         read_ctl(3'(i), v);
         check($sformatf("readback_reg%0d", i), regs[i], v);
      end

      // Pattern depends on every index bit
      for (int i = 0; i < TBL_WORDS; i++) begin
         write_table(i, 32'hc0de_0000 ^ (word_t'(i) * 32'h0009_e377));
      end
      configure(32'd5, 32'd700, 32'd0, 32'd1);
      go_and_check("single_lookup", 32'd5, 32'd700, 32'd0, 32'd1);

      for (int i = 0; i < TBL_WORDS; i++) begin
         write_table(i, rand_bits(32));
      end
      for (int r = 0; r < 10; r++) begin
         s0     = rand_bits(12);
         s1     = rand_bits(12);
         stride = rand_bits(11);
         count  = rand_bits(6) + 32'd1;
         configure(s0, s1, stride, count);
         go_and_check($sformatf("random_run%0d", r), s0, s1, stride, count);
      end

      configure(32'd17, 32'd900, 32'd3, 32'd0);
      go_and_check("count_zero", 32'd17, 32'd900, 32'd3, 32'd0);
      configure(32'd17, 32'd900, 32'd3, 32'd20);
      go_and_check("rerun_first", 32'd17, 32'd900, 32'd3, 32'd20);
      go_and_check("rerun_second", 32'd17, 32'd900, 32'd3, 32'd20);

      // A second GO mid-run with a new count must be dropped
      s0     = rand_bits(10);
      s1     = rand_bits(10);
      stride = rand_bits(10);
      configure(s0, s1, stride, 32'd40);
      write_ctl(REG_GO, 32'h1);
      read_ctl(REG_STATUS, v);
      check("busy_after_go", 32'h1, v);
      write_ctl(REG_COUNT, 32'd3);
      write_ctl(REG_GO, 32'h1);
      wait_idle();
      read_ctl(REG_RESULT, v);
      first = expected_sum(s0, s1, stride, 32'd40);
      check("go_while_busy", first, v);

      configure(s0, s1, stride, 32'd40);
      write_table(int'(s0 % TBL_WORDS), rand_bits(32));
      go_and_check("table_overwrite", s0, s1, stride, 32'd40);
      v = expected_sum(s0, s1, stride, 32'd40);
      if (v == first) begin
         abort_run("overwritten entry did not change the expected result");
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

//--- lut_top.sv
module lut_top
   import lut_pkg::*;
#(
   parameter int DATA_W = DATA_W_DEF,
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic                clk,
   input  logic                rst,

   input  logic                valid,
   input  logic [DATA_W/8-1:0] wstrb,
   input  haddr_t              addr,
   input  word_t               wdata,
   output logic                rvalid,
   output word_t               rdata
);

   logic       tbl_valid;
   baddr_t     tbl_addr;
   logic       tbl_rvalid;
   word_t      tbl_rdata;

   logic       ctl_valid;
   logic       ctl_write;
   logic [2:0] ctl_reg;
   logic       ctl_rvalid;
   word_t      ctl_rdata;

   idx_t       in0;
   idx_t       in1;
   word_t      out0;
   word_t      out1;
   logic       issue;
   logic       go;
   word_t      result;
   logic       done;

   baddr_t     p0_addr;
   word_t      p0_wdata;
   logic       p0_write;
   word_t      p0_rdata;
   baddr_t     p1_addr;
   word_t      p1_rdata;

   lut_bus_decode #(
      .ADDR_W(ADDR_W)
   ) decode_i (
      .clk       (clk),
      .rst       (rst),
      .valid     (valid),
      .wstrb     (wstrb),
      .addr      (addr),
      .rvalid    (rvalid),
      .rdata     (rdata),
      .tbl_valid (tbl_valid),
      .tbl_addr  (tbl_addr),
      .tbl_rvalid(tbl_rvalid),
      .tbl_rdata (tbl_rdata),
      .ctl_valid (ctl_valid),
      .ctl_write (ctl_write),
      .ctl_reg   (ctl_reg),
      .ctl_rvalid(ctl_rvalid),
      .ctl_rdata (ctl_rdata)
   );

   lut_addr_gen #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) addr_gen_i (
      .clk       (clk),
      .rst       (rst),
      .ctl_valid (ctl_valid),
      .ctl_write (ctl_write),
      .ctl_reg   (ctl_reg),
      .wdata     (wdata),
      .ctl_rvalid(ctl_rvalid),
      .ctl_rdata (ctl_rdata),
      .in0       (in0),
      .in1       (in1),
      .issue     (issue),
      .go        (go),
      .result    (result),
      .done      (done)
   );

   lut_unit #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) unit_i (
      .clk       (clk),
      .rst       (rst),
      .tbl_valid (tbl_valid),
      .wstrb     (wstrb),
      .tbl_addr  (tbl_addr),
      .wdata     (wdata),
      .tbl_rvalid(tbl_rvalid),
      .tbl_rdata (tbl_rdata),
      .in0       (in0),
      .in1       (in1),
      .out0      (out0),
      .out1      (out1),
      .p0_addr   (p0_addr),
      .p0_wdata  (p0_wdata),
      .p0_write  (p0_write),
      .p0_rdata  (p0_rdata),
      .p1_addr   (p1_addr),
      .p1_rdata  (p1_rdata)
   );

   lut_dp_ram #(
      .DATA_W(DATA_W),
      .ADDR_W(ADDR_W)
   ) ram_i (
      .clk     (clk),
      .p0_addr (p0_addr),
      .p0_wdata(p0_wdata),
      .p0_write(p0_write),
      .p0_rdata(p0_rdata),
      .p1_addr (p1_addr),
      .p1_rdata(p1_rdata)
   );

   lut_accum #(
      .DATA_W(DATA_W)
   ) accum_i (
      .clk   (clk),
      .rst   (rst),
      .go    (go),
      .issue (issue),
      .out0  (out0),
      .out1  (out1),
      .result(result),
      .done  (done)
   );

endmodule

//--- lut_bus_decode.sv
module lut_bus_decode
   import lut_pkg::*;
#(
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic       clk,
   input  logic       rst,

   input  logic       valid,
   input  logic [3:0] wstrb,
   input  haddr_t     addr,
   output logic       rvalid,
   output word_t      rdata,

   output logic       tbl_valid,
   output baddr_t     tbl_addr,
   input  logic       tbl_rvalid,
   input  word_t      tbl_rdata,

   output logic       ctl_valid,
   output logic       ctl_write,
   output logic [2:0] ctl_reg,
   input  logic       ctl_rvalid,
   input  word_t      ctl_rdata
);

   logic  ctl_sel;
   logic  rd_ctl;
   word_t rdata_mux;
   word_t rdata_q;

   // Region select
   assign ctl_sel = addr[ADDR_W];

   assign tbl_valid = valid && !ctl_sel;
   assign tbl_addr  = addr[ADDR_W-1:0];

   assign ctl_valid = valid && ctl_sel;
   assign ctl_write = (wstrb != '0);
   assign ctl_reg   = addr[4:2];

   // Both sides answer one cycle after the read, never together
   assign rvalid    = tbl_rvalid || ctl_rvalid;
   assign rdata_mux = rd_ctl ? ctl_rdata : tbl_rdata;
   assign rdata     = rvalid ? rdata_mux : rdata_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_ctl  <= 1'b0;
         rdata_q <= '0;
      end else begin
         if (valid && (wstrb == '0)) begin
            rd_ctl <= ctl_sel;
         end
         // Keep the last response on the bus
         if (rvalid) begin
            rdata_q <= rdata_mux;
         end
      end
   end

endmodule

//--- lut_accum.sv
module lut_accum
   import lut_pkg::*;
#(
   parameter int DATA_W = DATA_W_DEF
) (
   input  logic  clk,
   input  logic  rst,

   input  logic  go,
   input  logic  issue,
   input  word_t out0,
   input  word_t out1,

   output word_t result,
   output logic  done
);

   logic [DATA_W-1:0] sum;
   logic              issue_d1;
   logic              issue_d2;
   logic              pending;
   logic              last;

   // Delay line matches the two-cycle lookup latency
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         issue_d1 <= 1'b0;
         issue_d2 <= 1'b0;
      end else begin
         issue_d1 <= issue;
         issue_d2 <= issue_d1;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sum <= '0;
      end else if (go) begin
         sum <= '0;
      end else if (issue_d2) begin
         // Wraps modulo 2^DATA_W
         sum <= sum + out0 + out1;
      end
   end

   // Only the final aligned word may still be in stage two
   assign last = pending && !issue && !issue_d1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending <= 1'b0;
         done    <= 1'b0;
      end else begin
         done <= last;
         if (go) begin
            pending <= 1'b1;
         end else if (last) begin
            pending <= 1'b0;
         end
      end
   end

   assign result = sum;

endmodule

//--- lut_addr_gen.sv
module lut_addr_gen
   import lut_pkg::*;
#(
   parameter int DATA_W = DATA_W_DEF,
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic       clk,
   input  logic       rst,

   input  logic       ctl_valid,
   input  logic       ctl_write,
   input  logic [2:0] ctl_reg,
   input  word_t      wdata,
   output logic       ctl_rvalid,
   output word_t      ctl_rdata,

   output idx_t       in0,
   output idx_t       in1,
   output logic       issue,
   output logic       go,

   input  word_t      result,
   input  logic       done
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_DRAIN
   } state_t;

   state_t state;
   word_t  start0_q;
   word_t  start1_q;
   word_t  stride_q;
   word_t  count_q;
   word_t  remain;
   idx_t   idx0;
   idx_t   idx1;
   idx_t   step;
   word_t  status;
   logic   busy;
   logic   wr_en;
   logic   rd_en;

   assign wr_en = ctl_valid && ctl_write;
   assign rd_en = ctl_valid && !ctl_write;

   assign busy   = (state != ST_IDLE);
   assign status = {{(DATA_W-1){1'b0}}, busy};

   // GO is dropped while a run is in flight
   assign go = wr_en && (ctl_reg == REG_GO) && !busy;

   assign step  = idx_t'(stride_q[ADDR_W-3:0]);
   assign issue = (state == ST_RUN);
   assign in0   = idx0;
   assign in1   = idx1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start0_q <= '0;
         start1_q <= '0;
         stride_q <= '0;
         count_q  <= '0;
      end else if (wr_en) begin
         case (ctl_reg)
            REG_START0: start0_q <= wdata;
            REG_START1: start1_q <= wdata;
            REG_STRIDE: stride_q <= wdata;
            REG_COUNT:  count_q  <= wdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state  <= ST_IDLE;
         idx0   <= '0;
         idx1   <= '0;
         remain <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (go) begin
                  idx0   <= idx_t'(start0_q[ADDR_W-3:0]);
                  idx1   <= idx_t'(start1_q[ADDR_W-3:0]);
                  remain <= count_q;
                  state  <= (count_q == '0) ? ST_DRAIN : ST_RUN;
               end
            end
            ST_RUN: begin
               // Index wrap comes from the idx_t width
               idx0   <= idx0 + step;
               idx1   <= idx1 + step;
               remain <= remain - 1'b1;
               if (remain == word_t'(1)) begin
                  state <= ST_DRAIN;
               end
            end
            ST_DRAIN: begin
               if (done) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Register readback, one cycle after the access
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctl_rvalid <= 1'b0;
         ctl_rdata  <= '0;
      end else begin
         ctl_rvalid <= rd_en;
         if (rd_en) begin
            case (ctl_reg)
               REG_START0: ctl_rdata <= start0_q;
               REG_START1: ctl_rdata <= start1_q;
               REG_STRIDE: ctl_rdata <= stride_q;
               REG_COUNT:  ctl_rdata <= count_q;
               REG_RESULT: ctl_rdata <= result;
               REG_STATUS: ctl_rdata <= status;
               default:    ctl_rdata <= '0;
            endcase
         end
      end
   end

endmodule

//--- lut_dp_ram.sv
module lut_dp_ram
   import lut_pkg::*;
#(
   parameter int DATA_W = DATA_W_DEF,
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic   clk,

   input  baddr_t p0_addr,
   input  word_t  p0_wdata,
   input  logic   p0_write,
   output word_t  p0_rdata,

   input  baddr_t p1_addr,
   output word_t  p1_rdata
);

   localparam int DEPTH = 2 ** (ADDR_W - 2);

   logic [DATA_W-1:0] mem [DEPTH];

   logic [ADDR_W-3:0] p0_word;
   logic [ADDR_W-3:0] p1_word;

   // Byte address to word address
   assign p0_word = p0_addr[ADDR_W-1:2];
   assign p1_word = p1_addr[ADDR_W-1:2];

   // Port 0 read returns the old word on a collision
   always_ff @(posedge clk) begin
      if (p0_write) begin
         mem[p0_word] <= p0_wdata;
      end
      p0_rdata <= mem[p0_word];
   end

   always_ff @(posedge clk) begin
      p1_rdata <= mem[p1_word];
   end

endmodule

//--- lut_unit.sv
module lut_unit
   import lut_pkg::*;
#(
   parameter int DATA_W = DATA_W_DEF,
   parameter int ADDR_W = ADDR_W_DEF
) (
   input  logic              clk,
   input  logic              rst,

   input  logic              tbl_valid,
   input  logic [DATA_W/8-1:0] wstrb,
   input  baddr_t            tbl_addr,
   input  word_t             wdata,
   output logic              tbl_rvalid,
   output word_t             tbl_rdata,

   input  idx_t              in0,
   input  idx_t              in1,
   output word_t             out0,
   output word_t             out1,

   output baddr_t            p0_addr,
   output word_t             p0_wdata,
   output logic              p0_write,
   input  word_t             p0_rdata,
   output baddr_t            p1_addr,
   input  word_t             p1_rdata
);

   logic   wr_pending;
   baddr_t wr_addr;
   word_t  wr_data;
   logic   bus_write;
   logic   bus_read;

   // Any nonzero strobe writes the full word
   assign bus_write = tbl_valid && (wstrb != '0);
   assign bus_read  = tbl_valid && (wstrb == '0);

   // Table is write-only from the bus
   assign tbl_rdata = '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_pending <= 1'b0;
         wr_addr    <= '0;
         wr_data    <= '0;
         tbl_rvalid <= 1'b0;
      end else begin
         wr_pending <= bus_write;
         tbl_rvalid <= bus_read;
         if (bus_write) begin
            wr_addr <= tbl_addr;
            wr_data <= wdata;
         end
      end
   end

   // Pending write steals port 0 from lookup index 0
   assign p0_addr  = wr_pending ? wr_addr : {in0[ADDR_W-3:0], 2'b00};
   assign p0_wdata = wr_data;
   assign p0_write = wr_pending;

   assign p1_addr = {in1[ADDR_W-3:0], 2'b00};

   // Second stage of the lookup pipeline
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out0 <= '0;
         out1 <= '0;
      end else begin
         out0 <= p0_rdata;
         out1 <= p1_rdata;
      end
   end

endmodule

//--- lut_pkg.sv
package lut_pkg;

   // Default widths, overridden only at the top level
   localparam int DATA_W_DEF = 32;
   localparam int ADDR_W_DEF = 12;

   // Data word for bus, table and result
   typedef logic [DATA_W_DEF-1:0] word_t;

   // Word index into the table
   typedef logic [ADDR_W_DEF-3:0] idx_t;

   // Byte address into the table
   typedef logic [ADDR_W_DEF-1:0] baddr_t;

   // Host address, top bit picks the control region
   typedef logic [ADDR_W_DEF:0] haddr_t;

   // Control register word offsets
   localparam logic [2:0] REG_START0 = 3'd0;
   localparam logic [2:0] REG_START1 = 3'd1;
   localparam logic [2:0] REG_STRIDE = 3'd2;
   localparam logic [2:0] REG_COUNT  = 3'd3;
   localparam logic [2:0] REG_GO     = 3'd4;
   localparam logic [2:0] REG_RESULT = 3'd5;
   localparam logic [2:0] REG_STATUS = 3'd6;

endpackage
